//--- Makefile
VERILATOR ?= verilator
TOP       ?= prbs_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)

.PHONY: all compile run check clean

all: check

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) 2>&1 | tee $(LOG)

check: run
	@if grep -q "FAIL: see errors above" $(LOG) || ! grep -q "PASS: all tests" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/prbs_vectors.svh
`ifndef PRBS_VECTORS_SVH
`define PRBS_VECTORS_SVH

// one row per case with cfg (len, taps t3..t0, seed), expected period and corrupt word index
// corrupt index 0 leaves the looped-back stream clean
typedef struct packed {
    prbs_pkg::prbs_cfg_t  cfg;
    logic [31:0]          period;     // 2^len - 1, all rows use maximal taps
    logic [15:0]          corrupt;    // word number counted from the seed
} vec_row_t;

localparam int VEC_ROWS = 5;

localparam vec_row_t VEC_TABLE [VEC_ROWS] = '{
    '{cfg: '{len: 6'd3, taps: {6'd0, 6'd0, 6'd2, 6'd3}, seed: 32'h0000_0005},
      period: 32'd7,   corrupt: 16'd0},
    '{cfg: '{len: 6'd4, taps: {6'd0, 6'd0, 6'd3, 6'd4}, seed: 32'hffff_fff0},
      period: 32'd15,  corrupt: 16'd5},
    '{cfg: '{len: 6'd5, taps: {6'd0, 6'd0, 6'd3, 6'd5}, seed: 32'h0000_0013},
      period: 32'd31,  corrupt: 16'd0},
    '{cfg: '{len: 6'd7, taps: {6'd0, 6'd0, 6'd6, 6'd7}, seed: 32'h1234_5601},
      period: 32'd127, corrupt: 16'd40},
    '{cfg: '{len: 6'd8, taps: {6'd4, 6'd5, 6'd6, 6'd8}, seed: 32'hdead_beef},
      period: 32'd255, corrupt: 16'd100}
};

`endif

//--- bench/prbs_tb.sv
`timescale 1ns/1ns

module prbs_tb;

    `include "prbs_vectors.svh"

    logic                                   i_clk = 1'b0;
    logic                                   i_rst_n;
    prbs_pkg::prbs_cfg_t                    i_cfg;
    logic                                   i_start;
    logic                                   i_run;
    logic                                   i_rx_valid;
    logic [prbs_pkg::LFSR_WIDTH-1:0]        i_rx_data;
    logic                                   o_tx_valid;
    logic [prbs_pkg::LFSR_WIDTH-1:0]        o_tx_data;
    logic                                   o_wrap;
    logic [prbs_pkg::PERIOD_W-1:0]          o_period;
    logic                                   o_rx_locked;
    logic [prbs_pkg::ERR_CNT_W-1:0]         o_err_count;

    int                   n_checks = 0;
    int                   n_errors = 0;
    int                   cycle_cnt = 0;
    int                   cycle_limit = 0;    // set from the table at time 0
    prbs_pkg::prbs_cfg_t  row_cfg;            // config of the running row
    prbs_pkg::prbs_cfg_t  start_cfg;          // goes out with the next start
    logic [31:0]          row_period;
    logic [31:0]          ref_state;          // model word expected next
    logic [31:0]          held_word;          // model word now on the output
    logic [31:0]          prev_data;
    logic                 prev_valid = 1'b0;
    logic                 word_new = 1'b0;    // last sample was a fresh word
    int                   word_idx = 0;
    int                   words_seen = 0;
    int                   wrap_count = 0;
    int                   corrupt_idx = 0;

    always #2 i_clk = ~i_clk;                 // 4 ns period

    prbs_top uut (.*);

    //////////////////////////////////////////////////////////////////////
    // reference model and checks

    function automatic logic [31:0] low_ones(input logic [5:0] len);
        logic [32:0] ones;
        ones = (33'd1 << len) - 33'd1;
        return ones[31:0];
    endfunction

    // shift left with the xnor of tapped bits inside len into bit 0
    task automatic model_step(input prbs_pkg::prbs_cfg_t cfg, input logic [31:0] cur,
                              output logic [31:0] nxt);
        logic fb;
        fb = 1'b0;
        for (int t = 0; t < prbs_pkg::TAP_COUNT; t++) begin
            if (cfg.taps[t] != '0 && cfg.taps[t] <= cfg.len)
                fb = fb ^ cur[5'(cfg.taps[t] - 6'd1)];
        end
        nxt = {cur[30:0], ~fb} & low_ones(cfg.len);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run(input logic timed_out);
        $display("checks: %0d, errors: %0d, timeout: %0d", n_checks, n_errors, timed_out);
        if (n_errors == 0 && !timed_out)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    endtask

    function automatic int timeout_cycles();
        int sum;
        sum = 0;
        for (int r = 0; r < VEC_ROWS; r++)
            sum += int'(VEC_TABLE[r].period) + 20;
        return 2 * sum;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // one clock with drive on posedge and sample on negedge

    task automatic tick(input logic run_req, input logic start_req);
        logic run_eff;
        @(posedge i_clk);
        run_eff = i_run;                        // level the DUT takes at this edge
        i_run      <= run_req;
        i_start    <= start_req;
        i_cfg      <= start_req ? start_cfg : '0;   // only a start may sample it
        i_rx_valid <= word_new;                 // loopback with one word per valid
        i_rx_data  <= (word_new && corrupt_idx != 0 && word_idx == corrupt_idx)
                      ? prev_data ^ 32'h1 : prev_data;
        @(negedge i_clk);
        word_new = 1'b0;
        if (o_wrap) begin
            wrap_count++;
            check("o_period", o_period, row_period);
            check("o_tx_data at wrap", o_tx_data, row_cfg.seed & low_ones(row_cfg.len));
        end
        if (o_tx_valid && prev_valid && !run_eff) begin
            check("o_tx_data held", o_tx_data, held_word);
        end else if (o_tx_valid) begin
            if (!prev_valid) begin              // seed word of a new start
                ref_state = row_cfg.seed & low_ones(row_cfg.len);
                check("o_rx_locked", 32'(o_rx_locked), 0);
                check("o_err_count", 32'(o_err_count), 0);
            end
            check("o_tx_data", o_tx_data, ref_state);
            held_word = ref_state;
            model_step(row_cfg, ref_state, ref_state);
            word_new = 1'b1;
            word_idx = words_seen;
            words_seen++;
        end
        prev_valid = o_tx_valid;
        prev_data  = o_tx_data;
    endtask

    // stop_words 0 runs the full row with end checks
    // any other count cuts the row short
    task automatic run_row(input int r, input int stop_words);
        int target;
        start_cfg = VEC_TABLE[r].cfg;
        tick(1'b1, 1'b1);                       // start seen on the next edge
        row_cfg     = VEC_TABLE[r].cfg;
        row_period  = VEC_TABLE[r].period;
        corrupt_idx = (stop_words == 0) ? int'(VEC_TABLE[r].corrupt) : 0;
        target      = (stop_words == 0) ? int'(row_period) + 3 : stop_words;
        wrap_count  = 0;
        words_seen  = 0;
        while (words_seen < target)
            tick((($urandom % 8) != 0), 1'b0);  // run low about one cycle in eight
        if (stop_words == 0) begin
            repeat (3) tick(1'b0, 1'b0);        // checker takes the last word
            check("o_wrap pulse count", wrap_count, 1);
            check("o_period", o_period, row_period);
            check("o_rx_locked", 32'(o_rx_locked), 1);
            check("o_err_count", 32'(o_err_count), (corrupt_idx != 0) ? 1 : 0);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and timeout

    initial begin
        void'($urandom(32'h7c6dd9c4));
        cycle_limit = timeout_cycles();
        i_rst_n    = 1'b0;
        i_cfg      = '0;
        i_start    = 1'b0;
        i_run      = 1'b0;
        i_rx_valid = 1'b0;
        i_rx_data  = '0;
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check("o_tx_valid", 32'(o_tx_valid), 0);
        check("o_wrap", 32'(o_wrap), 0);
        check("o_rx_locked", 32'(o_rx_locked), 0);
        check("o_err_count", 32'(o_err_count), 0);
        check("o_period", o_period, 0);
        run_row(VEC_ROWS - 1, 8);               // cut short so row 0 restarts it
        for (int r = 0; r < VEC_ROWS; r++)
            run_row(r, 0);
        finish_run(1'b0);
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout reached after %0d cycles, the run did not finish", cycle_cnt);
            finish_run(1'b1);
        end
    end

endmodule : prbs_tb

//--- source/lfsr_shifter.sv
`timescale 1ns/1ns

// xnor fibonacci lfsr, taps and length set at runtime
module lfsr_shifter (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  prbs_pkg::prbs_cfg_t              i_cfg,     // len, taps, seed
    input  prbs_pkg::lfsr_cmd_t              i_cmd,     // load / step
    output logic [prbs_pkg::LFSR_WIDTH-1:0]  o_state,   // current word
    output logic [prbs_pkg::LFSR_WIDTH-1:0]  o_next,    // successor, comb
    output logic                             o_wrap     // state == masked seed
);

    logic [prbs_pkg::LFSR_WIDTH-1:0] state_q;
    logic [prbs_pkg::LFSR_WIDTH-1:0] len_mask;     // ones below len
    logic [prbs_pkg::LFSR_WIDTH-1:0] tap_mask;     // decoded tap bits
    logic                            feedback;

    //////////////////////////////////////////////////////////////////////
    // mask decode

    always_comb begin
        len_mask = '0;
        tap_mask = '0;
        for (int b = 0; b < prbs_pkg::LFSR_WIDTH; b++) begin
            len_mask[b] = (prbs_pkg::LEN_W'(b) < i_cfg.len);
            // index b+1 taps bit b, index 0 never matches
            for (int t = 0; t < prbs_pkg::TAP_COUNT; t++) begin
                if (i_cfg.taps[t] == prbs_pkg::TAP_IDX_W'(b + 1))
                    tap_mask[b] = 1'b1;
            end
        end
    end

    // xnor over tapped bits inside the active length
    assign feedback = ~^(state_q & tap_mask & len_mask);
    assign o_next   = {state_q[prbs_pkg::LFSR_WIDTH-2:0], feedback} & len_mask;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= '0;
        end else if (i_cmd.load) begin
            state_q <= i_cfg.seed & len_mask;   // bits above len dropped
        end else if (i_cmd.step) begin
            state_q <= o_next;
        end
    end

    assign o_state = state_q;
    assign o_wrap  = (state_q == (i_cfg.seed & len_mask));

    // both callers must keep load and step apart
    a_cmd_excl : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_cmd.load && i_cmd.step))
        else $error("lfsr_shifter: load and step together");

    // all ones is the xnor lockup, a legal state never steps into it
    a_no_lockup : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_cmd.step && !i_cmd.load && state_q != len_mask)
        |=> ((state_q & $past(len_mask)) != $past(len_mask)))
        else $error("lfsr_shifter: stepped into lockup state");

endmodule : lfsr_shifter

//--- source/prbs_checker.sv
`timescale 1ns/1ns

// self-synchronizing receive checker
// first valid word after clear seeds the predictor
module prbs_checker (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  prbs_pkg::prbs_cfg_t              i_cfg,         // len and taps used
    input  logic                             i_clear,       // drop lock, zero count
    input  logic                             i_rx_valid,
    input  logic [prbs_pkg::LFSR_WIDTH-1:0]  i_rx_data,
    output logic                             o_locked,
    output logic [prbs_pkg::ERR_CNT_W-1:0]   o_err_count
);

    logic                             locked_q;
    logic [prbs_pkg::ERR_CNT_W-1:0]   err_q;
    prbs_pkg::prbs_cfg_t              pred_cfg;     // config with rx seed
    prbs_pkg::lfsr_cmd_t              pred_cmd;
    logic [prbs_pkg::LFSR_WIDTH-1:0]  pred_next;    // expected word
    logic                             mismatch;

    //////////////////////////////////////////////////////////////////////
    // predictor

    // seed replaced by the received word
    always_comb begin
        pred_cfg      = i_cfg;
        pred_cfg.seed = i_rx_data;
    end

    assign pred_cmd.load = i_rx_valid && !locked_q && !i_clear;
    assign pred_cmd.step = i_rx_valid &&  locked_q && !i_clear;

    lfsr_shifter u_pred (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cfg   (pred_cfg),
        .i_cmd   (pred_cmd),
        .o_state (),
        .o_next  (pred_next),
        .o_wrap  ()
    );

    // full word compare, flips above len count too
    assign mismatch = pred_cmd.step && (i_rx_data != pred_next);

    //////////////////////////////////////////////////////////////////////
    // lock and error count

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            locked_q <= 1'b0;
            err_q    <= '0;
        end else if (i_clear) begin
            locked_q <= 1'b0;
            err_q    <= '0;
        end else begin
            if (pred_cmd.load)
                locked_q <= 1'b1;               // locked from next edge
            if (mismatch && err_q != '1)
                err_q <= err_q + 1'b1;          // saturates
        end
    end

    assign o_locked    = locked_q;
    assign o_err_count = err_q;

    // count only falls through clear
    a_err_monotonic : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_clear |=> (err_q >= $past(err_q)))
        else $error("prbs_checker: error count went down");

endmodule : prbs_checker

//--- source/prbs_ctrl.sv
`timescale 1ns/1ns

// start / run sequencing, config latch and period measurement
module prbs_ctrl (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  prbs_pkg::prbs_cfg_t             i_cfg,        // sampled on start only
    input  logic                            i_start,      // restart pulse
    input  logic                            i_run,        // level, low freezes
    input  logic                            i_gen_wrap,   // generator at seed
    output prbs_pkg::prbs_cfg_t             o_cfg,        // latched config
    output prbs_pkg::lfsr_cmd_t             o_gen_cmd,
    output logic                            o_chk_clear,  // one cycle after start
    output logic                            o_tx_valid,
    output logic                            o_wrap,       // first wrap only
    output logic [prbs_pkg::PERIOD_W-1:0]   o_period
);

    typedef enum logic [1:0] {
        ST_IDLE,    // out of reset, nothing loaded
        ST_SEED,    // generator takes seed this cycle
        ST_RUN      // stepping on i_run
    } state_t;

    state_t                          state_q;
    prbs_pkg::prbs_cfg_t             cfg_q;
    logic                            tx_valid_q;
    logic                            chk_clear_q;
    logic                            wrap_seen_q;  // period already taken
    logic [prbs_pkg::PERIOD_W-1:0]   cnt_q;        // steps since seed load
    logic [prbs_pkg::PERIOD_W-1:0]   period_q;
    logic                            gen_step;
    logic                            first_wrap;

    //////////////////////////////////////////////////////////////////////
    // generator command

    // a start in RUN restarts, no step on that edge
    assign gen_step       = (state_q == ST_RUN) && i_run && !i_start;
    assign o_gen_cmd.load = (state_q == ST_SEED);
    assign o_gen_cmd.step = gen_step;

    // back at seed after at least one step
    assign first_wrap = (state_q == ST_RUN) && i_gen_wrap
                     && (cnt_q != '0) && !wrap_seen_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q     <= ST_IDLE;
            cfg_q       <= '0;
            tx_valid_q  <= 1'b0;
            chk_clear_q <= 1'b0;
            wrap_seen_q <= 1'b0;
            cnt_q       <= '0;
            period_q    <= '0;
        end else begin
            chk_clear_q <= i_start;             // checker drops lock next cycle
            if (i_start) begin
                cfg_q       <= i_cfg;
                state_q     <= ST_SEED;
                tx_valid_q  <= 1'b0;
                wrap_seen_q <= 1'b0;
                cnt_q       <= '0;
                period_q    <= '0;
            end else begin
                case (state_q)
                    ST_SEED: begin
                        state_q    <= ST_RUN;
                        tx_valid_q <= 1'b1;     // seed word shows next cycle
                    end
                    ST_RUN: begin
                        if (first_wrap) begin
                            period_q    <= cnt_q;
                            wrap_seen_q <= 1'b1;
                        end else if (gen_step && !wrap_seen_q) begin
                            cnt_q <= cnt_q + 1'b1;  // stops after first wrap
                        end
                    end
                    default: ;                  // idle waits for start
                endcase
            end
        end
    end

    assign o_cfg       = cfg_q;
    assign o_chk_clear = chk_clear_q;
    assign o_tx_valid  = tx_valid_q;
    assign o_wrap      = first_wrap;
    assign o_period    = first_wrap ? cnt_q : period_q;   // visible in wrap cycle

    a_no_valid_idle : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state_q == ST_IDLE) |-> !o_tx_valid)
        else $error("prbs_ctrl: tx valid while idle");

    a_cnt_no_wrap : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!i_start && cnt_q != '0) |=> (cnt_q != '0))
        else $error("prbs_ctrl: period counter rolled over");

endmodule : prbs_ctrl

//--- source/prbs_pkg.sv
// shared widths and bundles for the prbs generator / checker

package prbs_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths

    localparam int LFSR_WIDTH = 32;     // physical register width
    localparam int TAP_COUNT  = 4;      // tap slots per polynomial
    localparam int TAP_IDX_W  = 6;      // one tap index, 0 = slot unused
    localparam int LEN_W      = 6;      // active length field, 3..32
    localparam int ERR_CNT_W  = 16;     // checker mismatch counter
    localparam int PERIOD_W   = 32;     // measured sequence period

    //////////////////////////////////////////////////////////////////////
    // bundles

    // run configuration, sampled on start
    // tap index k selects register bit k-1
    // e.g. len 8 with taps 8,6,5,4 for a maximal sequence
    typedef struct packed {
        logic [LEN_W-1:0]                      len;   // active bits
        logic [TAP_COUNT-1:0][TAP_IDX_W-1:0]   taps;  // tap indices
        logic [LFSR_WIDTH-1:0]                 seed;  // start state
    } prbs_cfg_t;

    // command into one lfsr instance
    // load and step are exclusive, load wins if both show up
    typedef struct packed {
        logic load;     // seed the register
        logic step;     // advance one state
    } lfsr_cmd_t;

endpackage : prbs_pkg

//--- source/prbs_top.sv
`timescale 1ns/1ns

// prbs generator and checker, top level
module prbs_top (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  prbs_pkg::prbs_cfg_t              i_cfg,
    input  logic                             i_start,
    input  logic                             i_run,
    input  logic                             i_rx_valid,
    input  logic [prbs_pkg::LFSR_WIDTH-1:0]  i_rx_data,
    output logic                             o_tx_valid,
    output logic [prbs_pkg::LFSR_WIDTH-1:0]  o_tx_data,
    output logic                             o_wrap,
    output logic [prbs_pkg::PERIOD_W-1:0]    o_period,
    output logic                             o_rx_locked,
    output logic [prbs_pkg::ERR_CNT_W-1:0]   o_err_count
);

    prbs_pkg::prbs_cfg_t  cfg_q;        // latched at start
    prbs_pkg::lfsr_cmd_t  gen_cmd;
    logic                 gen_wrap;
    logic                 chk_clear;

    //////////////////////////////////////////////////////////////////////
    // control

    prbs_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cfg       (i_cfg),
        .i_start     (i_start),
        .i_run       (i_run),
        .i_gen_wrap  (gen_wrap),
        .o_cfg       (cfg_q),
        .o_gen_cmd   (gen_cmd),
        .o_chk_clear (chk_clear),
        .o_tx_valid  (o_tx_valid),
        .o_wrap      (o_wrap),
        .o_period    (o_period)
    );

    // generator, next-state output not needed on tx side
    lfsr_shifter u_gen (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cfg   (cfg_q),
        .i_cmd   (gen_cmd),
        .o_state (o_tx_data),
        .o_next  (),
        .o_wrap  (gen_wrap)
    );

    prbs_checker u_chk (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cfg       (cfg_q),
        .i_clear     (chk_clear),
        .i_rx_valid  (i_rx_valid),
        .i_rx_data   (i_rx_data),
        .o_locked    (o_rx_locked),
        .o_err_count (o_err_count)
    );

endmodule : prbs_top

//--- sources.f
+incdir+bench
source/prbs_pkg.sv
source/lfsr_shifter.sv
source/prbs_ctrl.sv
source/prbs_checker.sv
source/prbs_top.sv
bench/prbs_tb.sv
